// File: design/pixel_mem_if.sv
`timescale 1ns/1ps

interface pixel_mem_if;

	logic strobe; // one-cycle request.
	logic write; // high for a write, low for a read.
	logic [sprite_pkg::addr_w-1:0] addr; // word address in the pixel memory.
	logic [sprite_pkg::color_w-1:0] wdata; // colour to store on a write.
	logic [sprite_pkg::color_w-1:0] rdata; // colour returned one cycle after a read.

	modport requester (
		output strobe, write, addr, wdata,
		input rdata
	);

	modport arbiter (
		input strobe, write, addr, wdata,
		output rdata
	);

endinterface

// File: design/pixel_memory_arbiter.sv
`timescale 1ns/1ps

module pixel_memory_arbiter (
	input logic clk,
	input logic reset,
	input logic video_enable,
	input logic cfg_strobe,
	input sprite_pkg::cfg_target_e cfg_target,
	input logic [sprite_pkg::addr_w-1:0] cfg_addr,
	input logic [sprite_pkg::cfg_data_w-1:0] cfg_data,
	output logic pixel_valid,
	output logic [sprite_pkg::color_w-1:0] pixel_color,
	pixel_mem_if.arbiter bg_port,
	pixel_mem_if.arbiter spr_port
);

	logic [sprite_pkg::color_w-1:0] mem [2**sprite_pkg::addr_w]; // the colour store.
	logic pix_strobe; // a pixel requester is active.
	logic pix_write; // selected requester wants a write.
	logic [sprite_pkg::addr_w-1:0] pix_addr; // selected requester address.
	logic [sprite_pkg::color_w-1:0] pix_wdata; // selected requester data.
	logic host_we; // host write accepted this cycle.
	logic mem_we; // memory write enable after arbitration.
	logic [sprite_pkg::addr_w-1:0] mem_addr; // memory address after arbitration.
	logic [sprite_pkg::color_w-1:0] mem_wdata; // memory write data after arbitration.
	logic [sprite_pkg::color_w-1:0] rd_color; // registered read colour.

	//////////////////////////////////////////////////
	// fixed priority with pixel requests before the host.
	//////////////////////////////////////////////////
	assign pix_strobe = bg_port.strobe || spr_port.strobe;
	assign pix_write = bg_port.strobe ? bg_port.write : spr_port.write;
	assign pix_addr = bg_port.strobe ? bg_port.addr : spr_port.addr;
	assign pix_wdata = bg_port.strobe ? bg_port.wdata : spr_port.wdata;
	assign host_we = cfg_strobe && !video_enable && (cfg_target == sprite_pkg::cfg_pixel_mem);
	assign mem_we = pix_strobe ? pix_write : host_we;
	assign mem_addr = pix_strobe ? pix_addr : cfg_addr;
	assign mem_wdata = pix_strobe ? pix_wdata : cfg_data[sprite_pkg::color_w-1:0];

	always_ff @(posedge clk) begin
		if (mem_we) begin
			mem[mem_addr] <= mem_wdata;
		end
		rd_color <= mem[mem_addr]; // read data follows the address by one cycle.
	end

	always_ff @(posedge clk or negedge reset) begin
		if (!reset) begin
			pixel_valid <= 1'b0;
		end else begin
			pixel_valid <= pix_strobe && !pix_write; // only pixel reads produce a colour.
		end
	end

	assign pixel_color = rd_color;
	assign bg_port.rdata = rd_color; // both requesters see the same read bus.
	assign spr_port.rdata = rd_color;

	assert property (@(posedge clk) disable iff (!reset) !(bg_port.strobe && spr_port.strobe))
		else $error("background and sprite reads collided");

endmodule

// File: design/print_controller.sv
`timescale 1ns/1ps

module print_controller (
	input logic clk,
	input logic reset,
	input logic pixel_tick,
	input logic active_area,
	input logic [sprite_pkg::x_w-1:0] pixel_x,
	input logic [sprite_pkg::y_w-1:0] pixel_y,
	input sprite_pkg::check_result_t check_result,
	input logic count_finished,
	output logic check_strobe,
	output logic [sprite_pkg::x_w-1:0] check_x,
	output logic [sprite_pkg::y_w-1:0] check_y,
	output logic sprite_start,
	pixel_mem_if.requester bg_port
);

	sprite_pkg::print_state_e state; // current per-pixel step.
	sprite_pkg::print_state_e next; // step for the next cycle.

	always_ff @(posedge clk or negedge reset) begin
		if (!reset) begin
			state <= sprite_pkg::receive;
		end else begin
			state <= next;
		end
	end

	//////////////////////////////////////////////////
	// per-pixel sequence of four cycles on either path.
	//////////////////////////////////////////////////
	always_comb begin
		next = state; // hold unless a step below moves on.
		case (state)
			sprite_pkg::receive: begin
				if (pixel_tick && active_area) begin
					next = sprite_pkg::process; // the bank registers the coordinate now.
				end
			end
			sprite_pkg::process: begin
				next = check_result.hit ? sprite_pkg::sprite : sprite_pkg::wait_1;
			end
			sprite_pkg::sprite: begin
				if (count_finished) begin
					next = sprite_pkg::receive; // the line drawer has issued its read.
				end
			end
			sprite_pkg::wait_1: next = sprite_pkg::wait_2; // pads the background path.
			sprite_pkg::wait_2: next = sprite_pkg::receive;
			default: next = sprite_pkg::receive;
		endcase
	end

	assign check_strobe = (state == sprite_pkg::receive) && pixel_tick && active_area;
	assign check_x = pixel_x; // the bank latches these on check_strobe.
	assign check_y = pixel_y;
	assign sprite_start = (state == sprite_pkg::process) && check_result.hit; // one cycle only.

	// the background colour read is issued in the last wait step.
	assign bg_port.strobe = (state == sprite_pkg::wait_2);
	assign bg_port.write = 1'b0; // this path only reads.
	assign bg_port.addr = sprite_pkg::background_addr;
	assign bg_port.wdata = '0;

	assert property (@(posedge clk) disable iff (!reset)
		$fell(state == sprite_pkg::receive) |-> ##[1:3] (state == sprite_pkg::receive))
		else $error("pixel sequence took longer than four cycles");

endmodule

// File: design/raster_timing.sv
`timescale 1ns/1ps

module raster_timing (
	input logic clk,
	input logic reset,
	input logic video_enable,
	output logic pixel_tick,
	output logic hsync,
	output logic vsync,
	output logic active_area,
	output logic printing,
	output logic [sprite_pkg::x_w-1:0] pixel_x,
	output logic [sprite_pkg::y_w-1:0] pixel_y
);

	logic [sprite_pkg::tick_w-1:0] tick_cnt; // position inside the current pixel period.
	logic [sprite_pkg::cnt_w-1:0] v_count; // full line counter, blanking included.
	logic [sprite_pkg::x_w-1:0] h_next; // column after this tick.
	logic [sprite_pkg::cnt_w-1:0] v_next; // line after this tick.

	assign pixel_tick = video_enable && (tick_cnt == sprite_pkg::pixel_period - 1); // last cycle.
	assign h_next = (pixel_x == sprite_pkg::h_total - 1) ? '0 : pixel_x + 1'b1;
	assign v_next = (pixel_x != sprite_pkg::h_total - 1) ? v_count :
		(v_count == sprite_pkg::v_total - 1) ? '0 : v_count + 1'b1; // wraps at end of line.
	assign active_area = (pixel_x < sprite_pkg::screen_w) && (v_count < sprite_pkg::screen_h);
	assign pixel_y = v_count[sprite_pkg::y_w-1:0]; // only meaningful inside the visible rows.

	always_ff @(posedge clk or negedge reset) begin
		if (!reset) begin
			tick_cnt <= '0;
			pixel_x <= '0;
			v_count <= '0;
			hsync <= 1'b0;
			vsync <= 1'b0;
			printing <= 1'b0;
		end else if (!video_enable) begin
			tick_cnt <= '0; // the raster restarts at the top left when video comes on.
			pixel_x <= '0;
			v_count <= '0;
			hsync <= 1'b0;
			vsync <= 1'b0;
			printing <= 1'b0;
		end else begin
			tick_cnt <= pixel_tick ? '0 : tick_cnt + 1'b1;
			if (pixel_tick) begin
				pixel_x <= h_next;
				v_count <= v_next;
				hsync <= (h_next >= sprite_pkg::h_sync_start) && (h_next < sprite_pkg::h_sync_end);
				vsync <= (v_next >= sprite_pkg::v_sync_start) && (v_next < sprite_pkg::v_sync_end);
				printing <= active_area; // covers the colours of the pixel just taken.
			end
		end
	end

	assert property (@(posedge clk) disable iff (!reset) pixel_x < sprite_pkg::h_total)
		else $error("horizontal counter left the line");

endmodule

// File: design/sprite_engine_top.sv
`timescale 1ns/1ps

module sprite_engine_top (
	input logic clk,
	input logic reset,
	input logic video_enable,
	input logic cfg_strobe,
	input sprite_pkg::cfg_target_e cfg_target,
	input logic [sprite_pkg::addr_w-1:0] cfg_addr,
	input logic [sprite_pkg::cfg_data_w-1:0] cfg_data,
	output logic hsync,
	output logic vsync,
	output logic printing,
	output logic pixel_valid,
	output logic [sprite_pkg::color_w-1:0] pixel_color
);

	logic pixel_tick; // one cycle in every pixel period.
	logic active_area; // raster sits in the visible window.
	logic [sprite_pkg::x_w-1:0] pixel_x; // current column.
	logic [sprite_pkg::y_w-1:0] pixel_y; // current row.
	logic check_strobe; // controller asks the bank about a coordinate.
	logic [sprite_pkg::x_w-1:0] check_x;
	logic [sprite_pkg::y_w-1:0] check_y;
	sprite_pkg::check_result_t check_result; // registered answer of the bank.
	logic sprite_start; // a sprite covers the pixel.
	logic count_finished; // sprite read has been issued.

	pixel_mem_if bg_if (); // background reads.
	pixel_mem_if spr_if (); // sprite texel reads.

	raster_timing u_raster (.clk(clk), .reset(reset), .video_enable(video_enable),
		.pixel_tick(pixel_tick), .hsync(hsync), .vsync(vsync), .active_area(active_area),
		.printing(printing), .pixel_x(pixel_x), .pixel_y(pixel_y));

	sprite_register_bank u_bank (.clk(clk), .reset(reset), .cfg_strobe(cfg_strobe),
		.cfg_target(cfg_target), .cfg_addr(cfg_addr), .cfg_data(cfg_data),
		.check_strobe(check_strobe), .check_x(check_x), .check_y(check_y),
		.check_result(check_result));

	print_controller u_print (.clk(clk), .reset(reset), .pixel_tick(pixel_tick),
		.active_area(active_area), .pixel_x(pixel_x), .pixel_y(pixel_y),
		.check_result(check_result), .count_finished(count_finished),
		.check_strobe(check_strobe), .check_x(check_x), .check_y(check_y),
		.sprite_start(sprite_start), .bg_port(bg_if.requester));

	sprite_line_drawer u_drawer (.clk(clk), .reset(reset), .sprite_start(sprite_start),
		.check_result(check_result), .count_finished(count_finished),
		.spr_port(spr_if.requester));

	pixel_memory_arbiter u_arbiter (.clk(clk), .reset(reset), .video_enable(video_enable),
		.cfg_strobe(cfg_strobe), .cfg_target(cfg_target), .cfg_addr(cfg_addr),
		.cfg_data(cfg_data), .pixel_valid(pixel_valid), .pixel_color(pixel_color),
		.bg_port(bg_if.arbiter), .spr_port(spr_if.arbiter));

endmodule

// File: design/sprite_line_drawer.sv
`timescale 1ns/1ps

module sprite_line_drawer (
	input logic clk,
	input logic reset,
	input logic sprite_start,
	input sprite_pkg::check_result_t check_result,
	output logic count_finished,
	pixel_mem_if.requester spr_port
);

	logic [sprite_pkg::addr_w-1:0] row_term; // row offset widened to an address.
	logic [sprite_pkg::addr_w-1:0] col_term; // column offset widened to an address.
	logic [sprite_pkg::addr_w-1:0] texel_addr; // address of the covering texel.
	logic addr_ready; // texel_addr is valid this cycle.
	logic read_strobe; // read goes to the arbiter this cycle.

	assign row_term = {{(sprite_pkg::addr_w - sprite_pkg::off_w){1'b0}}, check_result.row};
	assign col_term = {{(sprite_pkg::addr_w - sprite_pkg::off_w){1'b0}}, check_result.col};

	always_ff @(posedge clk) begin
		if (sprite_start) begin
			texel_addr <= check_result.base + row_term * sprite_pkg::sprite_size + col_term;
		end
	end

	always_ff @(posedge clk or negedge reset) begin
		if (!reset) begin
			addr_ready <= 1'b0;
			read_strobe <= 1'b0;
		end else begin
			addr_ready <= sprite_start; // address settles one cycle after the start.
			read_strobe <= addr_ready; // and the read follows one cycle later.
		end
	end

	assign count_finished = read_strobe; // the controller may return to receive.
	assign spr_port.strobe = read_strobe;
	assign spr_port.write = 1'b0; // sprites are only read here.
	assign spr_port.addr = texel_addr;
	assign spr_port.wdata = '0;

endmodule

// File: design/sprite_pkg.sv
package sprite_pkg;

	//////////////////////////////////////////////////
	// raster geometry of the 640 by 480 mode.
	//////////////////////////////////////////////////
	localparam int x_w = 10; // horizontal coordinate width.
	localparam int y_w = 9; // visible rows fit in nine bits.
	localparam int cnt_w = 10; // the vertical counter runs to 524 and needs ten bits.
	localparam logic [x_w-1:0] screen_w = 10'd640; // visible columns.
	localparam logic [cnt_w-1:0] screen_h = 10'd480; // visible rows.
	localparam logic [x_w-1:0] h_total = 10'd800; // columns per line including blanking.
	localparam logic [cnt_w-1:0] v_total = 10'd525; // lines per frame including blanking.
	localparam logic [x_w-1:0] h_sync_start = 10'd656; // first column of the hsync pulse.
	localparam logic [x_w-1:0] h_sync_end = 10'd752; // first column after the hsync pulse.
	localparam logic [cnt_w-1:0] v_sync_start = 10'd490; // first line of the vsync pulse.
	localparam logic [cnt_w-1:0] v_sync_end = 10'd492; // first line after the vsync pulse.
	localparam int pixel_period = 4; // clk cycles per pixel.
	localparam int tick_w = 2; // width of the pixel divider.

	//////////////////////////////////////////////////
	// pixel memory and sprite sizes.
	//////////////////////////////////////////////////
	localparam int addr_w = 14; // 16384 colour words.
	localparam int color_w = 8; // one byte per colour.
	localparam logic [addr_w-1:0] background_addr = 14'd16383; // last word is the background.
	localparam int off_w = 4; // offset inside a sprite.
	localparam logic [off_w:0] sprite_size = 5'd16; // sprites are square.
	localparam int sprite_count = 4; // number of descriptor slots.
	localparam int slot_w = 2; // slot index taken from the low address bits.
	localparam int cfg_data_w = 34; // wide enough for a whole descriptor.

	typedef enum logic [2:0] {receive, process, sprite, wait_1, wait_2} print_state_e;
	typedef enum logic {cfg_pixel_mem, cfg_sprite_slot} cfg_target_e;

	typedef struct packed {
		logic enable; // slot takes part in the coverage check.
		logic [x_w-1:0] x; // left column of the sprite.
		logic [y_w-1:0] y; // top row of the sprite.
		logic [addr_w-1:0] base; // first texel in the pixel memory.
	} sprite_desc_t;

	typedef struct packed {
		logic hit; // some enabled sprite covers the pixel.
		logic [off_w-1:0] row; // row inside the winning sprite.
		logic [off_w-1:0] col; // column inside the winning sprite.
		logic [addr_w-1:0] base; // texel base of the winning sprite.
	} check_result_t;

endpackage

// File: design/sprite_register_bank.sv
`timescale 1ns/1ps

module sprite_register_bank (
	input logic clk,
	input logic reset,
	input logic cfg_strobe,
	input sprite_pkg::cfg_target_e cfg_target,
	input logic [sprite_pkg::addr_w-1:0] cfg_addr,
	input logic [sprite_pkg::cfg_data_w-1:0] cfg_data,
	input logic check_strobe,
	input logic [sprite_pkg::x_w-1:0] check_x,
	input logic [sprite_pkg::y_w-1:0] check_y,
	output sprite_pkg::check_result_t check_result
);

	sprite_pkg::sprite_desc_t slots [sprite_pkg::sprite_count]; // descriptor registers.
	logic [sprite_pkg::x_w-1:0] dx [sprite_pkg::sprite_count]; // column distance per slot.
	logic [sprite_pkg::y_w-1:0] dy [sprite_pkg::sprite_count]; // row distance per slot.
	logic [sprite_pkg::sprite_count-1:0] covers; // slot i covers the coordinate.
	sprite_pkg::check_result_t result_next; // winner before the register.

	//////////////////////////////////////////////////
	// host writes into the slots.
	//////////////////////////////////////////////////
	always_ff @(posedge clk or negedge reset) begin
		if (!reset) begin
			for (int i = 0; i < sprite_pkg::sprite_count; i++) begin
				slots[i] <= '0; // every slot starts disabled.
			end
		end else if (cfg_strobe && (cfg_target == sprite_pkg::cfg_sprite_slot)) begin
			slots[cfg_addr[sprite_pkg::slot_w-1:0]] <= sprite_pkg::sprite_desc_t'(cfg_data);
		end
	end

	//////////////////////////////////////////////////
	// coverage check where the lowest slot wins.
	//////////////////////////////////////////////////
	always_comb begin
		for (int i = 0; i < sprite_pkg::sprite_count; i++) begin
			dx[i] = check_x - slots[i].x; // wraps when the pixel lies left of the sprite.
			dy[i] = check_y - slots[i].y;
			covers[i] = slots[i].enable && (check_x >= slots[i].x) && (check_y >= slots[i].y) &&
				(dx[i] < sprite_pkg::sprite_size) && (dy[i] < sprite_pkg::sprite_size);
		end
	end

	always_comb begin
		result_next = '0; // a miss carries no offsets.
		for (int i = sprite_pkg::sprite_count - 1; i >= 0; i--) begin
			if (covers[i]) begin
				result_next.hit = 1'b1; // lower slots overwrite higher ones.
				result_next.row = dy[i][sprite_pkg::off_w-1:0];
				result_next.col = dx[i][sprite_pkg::off_w-1:0];
				result_next.base = slots[i].base;
			end
		end
	end

	always_ff @(posedge clk or negedge reset) begin
		if (!reset) begin
			check_result <= '0;
		end else if (check_strobe) begin
			check_result <= result_next; // held until the next pixel is checked.
		end
	end

endmodule

// File: filelist.f
design/sprite_pkg.sv
design/pixel_mem_if.sv
design/raster_timing.sv
design/sprite_register_bank.sv
design/print_controller.sv
design/sprite_line_drawer.sv
design/pixel_memory_arbiter.sv
design/sprite_engine_top.sv
verification/sprite_engine_checker.sv
verification/sprite_engine_tb.sv

// File: verification/sprite_engine_checker.sv
`timescale 1ns/1ps

module sprite_engine_checker (
	input logic clk,
	input logic reset,
	input logic video_enable,
	input logic cfg_strobe,
	input sprite_pkg::cfg_target_e cfg_target,
	input logic [sprite_pkg::addr_w-1:0] cfg_addr,
	input logic [sprite_pkg::cfg_data_w-1:0] cfg_data,
	input logic hsync,
	input logic vsync,
	input logic printing,
	input logic pixel_valid,
	input logic [sprite_pkg::color_w-1:0] pixel_color,
	input logic exp_strobe,
	input logic [sprite_pkg::x_w-1:0] exp_x,
	input logic [sprite_pkg::y_w-1:0] exp_y,
	input logic [sprite_pkg::color_w-1:0] exp_color,
	output int error_count,
	output int pixel_count,
	output logic frame_done
);

	logic [sprite_pkg::color_w-1:0] mem_model [2**sprite_pkg::addr_w]; // colours seen written.
	sprite_pkg::sprite_desc_t slot_model [sprite_pkg::sprite_count]; // descriptors seen written.
	int exp_xq [$]; // expected pixels from the data file in raster order.
	int exp_yq [$];
	logic [sprite_pkg::color_w-1:0] exp_cq [$];
	int cycle; // posedge count since time zero.
	int last_valid; // cycle of the latest colour strobe.
	int hsync_rise; // cycle where hsync last went high.
	int vsync_rise;
	int line_x; // column of the next colour in this line.
	int line_y; // visible row that advances on each hsync closing a pixel line.
	int frame_pix; // colours seen in the current frame.
	logic hsync_d; // sync levels one cycle back for edge detection.
	logic vsync_d;

	task automatic report_mismatch(input string msg);
		error_count++;
		$display("[FAIL] %0t ns: %s", $time, msg);
	endtask

	task automatic note_failure(input string msg);
		error_count++;
		$display("error: %s", msg);
	endtask

	//////////////////////////////////////////////////
	// reference colour from the memory and slot models.
	//////////////////////////////////////////////////
	function automatic logic [sprite_pkg::color_w-1:0] model_color(input int x, input int y);
		int s;
		int col;
		int row;
		int addr;
		for (s = 0; s < sprite_pkg::sprite_count; s++) begin // slot 0 is tried first.
			col = x - int'(slot_model[s].x);
			row = y - int'(slot_model[s].y);
			if (slot_model[s].enable && col >= 0 && row >= 0 &&
				col < int'(sprite_pkg::sprite_size) && row < int'(sprite_pkg::sprite_size)) begin
				addr = (int'(slot_model[s].base) + row * int'(sprite_pkg::sprite_size) + col) %
					(2 ** sprite_pkg::addr_w); // texel addresses wrap around the memory.
				return mem_model[addr];
			end
		end
		return mem_model[sprite_pkg::background_addr]; // nothing covers the pixel.
	endfunction

	// cycles from the last colour of a run to a sync edge when positions are counted in ticks.
	function automatic int sync_gap(input int sync_pos, input int last_pos);
		return sprite_pkg::pixel_period * (sync_pos - last_pos - 2) + 1;
	endfunction

	task automatic record_write();
		if (cfg_target == sprite_pkg::cfg_pixel_mem) begin
			mem_model[cfg_addr] = cfg_data[sprite_pkg::color_w-1:0];
		end else begin
			slot_model[cfg_addr % sprite_pkg::sprite_count] = sprite_pkg::sprite_desc_t'(cfg_data);
		end
	endtask

	task automatic check_pixel();
		logic [sprite_pkg::color_w-1:0] want;
		want = model_color(line_x, line_y);
		pixel_count++;
		frame_pix++;
		if (!printing) note_failure("pixel_valid came outside the printing window");
		if (line_x > 0 && cycle - last_valid != sprite_pkg::pixel_period)
			report_mismatch($sformatf("colours %0d cycles apart in row %0d",
				cycle - last_valid, line_y));
		if (pixel_color !== want)
			report_mismatch($sformatf("pixel (%0d,%0d) shows %h, model gives %h",
				line_x, line_y, pixel_color, want));
		if (exp_xq.size() > 0 && exp_xq[0] == line_x && exp_yq[0] == line_y) begin
			if (pixel_color !== exp_cq[0])
				report_mismatch($sformatf("pixel (%0d,%0d) shows %h, file expects %h",
					line_x, line_y, pixel_color, exp_cq[0]));
			void'(exp_xq.pop_front()); // this file entry is done.
			void'(exp_yq.pop_front());
			void'(exp_cq.pop_front());
		end
		last_valid = cycle;
		line_x++;
	endtask

	task automatic close_line();
		if (line_x != 0) begin // blank lines carry no colours.
			if (line_x != int'(sprite_pkg::screen_w))
				report_mismatch($sformatf("row %0d carried %0d colours", line_y, line_x));
			if (cycle - last_valid != sync_gap(int'(sprite_pkg::h_sync_start),
				int'(sprite_pkg::screen_w) - 1))
				report_mismatch($sformatf("hsync rose %0d cycles after row %0d ended",
					cycle - last_valid, line_y));
			line_y++;
		end
		line_x = 0;
		hsync_rise = cycle;
	endtask

	task automatic close_frame();
		if (frame_pix != int'(sprite_pkg::screen_w) * int'(sprite_pkg::screen_h))
			report_mismatch($sformatf("frame carried %0d colours", frame_pix));
		if (cycle - last_valid != sync_gap(
			int'(sprite_pkg::v_sync_start) * int'(sprite_pkg::h_total),
			(int'(sprite_pkg::screen_h) - 1) * int'(sprite_pkg::h_total) +
			int'(sprite_pkg::screen_w) - 1))
			report_mismatch($sformatf("vsync rose %0d cycles after the last colour",
				cycle - last_valid));
		if (exp_xq.size() != 0)
			note_failure($sformatf("%0d expected pixels from the file were never shown",
				exp_xq.size()));
		line_y = 0;
		frame_pix = 0;
		vsync_rise = cycle;
	endtask

	initial begin
		error_count = 0;
		pixel_count = 0;
		frame_done = 1'b0;
		cycle = 0;
		last_valid = 0;
		hsync_rise = 0;
		vsync_rise = 0;
		line_x = 0;
		line_y = 0;
		frame_pix = 0;
		hsync_d = 1'b0;
		vsync_d = 1'b0;
		for (int s = 0; s < sprite_pkg::sprite_count; s++) slot_model[s] = '0; // all disabled.
		forever begin
			@(posedge clk); // DUT outputs still hold their values from before this edge.
			cycle++;
			if (reset) begin
				if (cfg_strobe && !video_enable) record_write(); // writes in video are dropped.
				if (exp_strobe) begin
					exp_xq.push_back(int'(exp_x));
					exp_yq.push_back(int'(exp_y));
					exp_cq.push_back(exp_color);
				end
				if (!video_enable && (pixel_valid || hsync || vsync || printing))
					note_failure("an output was active while video was still disabled");
				if (pixel_valid) check_pixel();
				if (hsync && !hsync_d) close_line();
				if (!hsync && hsync_d && cycle - hsync_rise != sprite_pkg::pixel_period *
					(int'(sprite_pkg::h_sync_end) - int'(sprite_pkg::h_sync_start)))
					report_mismatch($sformatf("hsync was %0d cycles wide", cycle - hsync_rise));
				if (vsync && !vsync_d) close_frame();
				if (!vsync && vsync_d) begin
					if (cycle - vsync_rise != sprite_pkg::pixel_period *
						int'(sprite_pkg::h_total) *
						(int'(sprite_pkg::v_sync_end) - int'(sprite_pkg::v_sync_start)))
						report_mismatch($sformatf("vsync was %0d cycles wide",
							cycle - vsync_rise));
					frame_done = 1'b1; // one whole frame has been checked.
				end
				hsync_d = hsync;
				vsync_d = vsync;
			end
		end
	end

endmodule

// File: verification/sprite_engine_tb.sv
`timescale 1ns/1ps

module sprite_engine_tb;

	logic clk;
	logic reset;
	logic video_enable;
	logic cfg_strobe;
	sprite_pkg::cfg_target_e cfg_target;
	logic [sprite_pkg::addr_w-1:0] cfg_addr;
	logic [sprite_pkg::cfg_data_w-1:0] cfg_data;
	logic hsync;
	logic vsync;
	logic printing;
	logic pixel_valid;
	logic [sprite_pkg::color_w-1:0] pixel_color;
	logic exp_strobe; // hands one expected pixel to the checker.
	logic [sprite_pkg::x_w-1:0] exp_x;
	logic [sprite_pkg::y_w-1:0] exp_y;
	logic [sprite_pkg::color_w-1:0] exp_color;
	int error_count;
	int pixel_count;
	logic frame_done;
	int seed; // $random state for the memory fill.
	int cycle_count;
	int cycle_limit; // zero until the data file has been read.
	int wq_target [$]; // writes made before video starts.
	logic [sprite_pkg::addr_w-1:0] wq_addr [$];
	logic [sprite_pkg::cfg_data_w-1:0] wq_data [$];
	logic [sprite_pkg::addr_w-1:0] xq_addr [$]; // writes made while video runs.
	logic [sprite_pkg::cfg_data_w-1:0] xq_data [$];
	logic [sprite_pkg::x_w-1:0] eq_x [$]; // expected pixels.
	logic [sprite_pkg::y_w-1:0] eq_y [$];
	logic [sprite_pkg::color_w-1:0] eq_c [$];

	sprite_engine_top i_dut (.clk(clk), .reset(reset), .video_enable(video_enable),
		.cfg_strobe(cfg_strobe), .cfg_target(cfg_target), .cfg_addr(cfg_addr),
		.cfg_data(cfg_data), .hsync(hsync), .vsync(vsync), .printing(printing),
		.pixel_valid(pixel_valid), .pixel_color(pixel_color));

	sprite_engine_checker u_checker (.clk(clk), .reset(reset), .video_enable(video_enable),
		.cfg_strobe(cfg_strobe), .cfg_target(cfg_target), .cfg_addr(cfg_addr),
		.cfg_data(cfg_data), .hsync(hsync), .vsync(vsync), .printing(printing),
		.pixel_valid(pixel_valid), .pixel_color(pixel_color), .exp_strobe(exp_strobe),
		.exp_x(exp_x), .exp_y(exp_y), .exp_color(exp_color), .error_count(error_count),
		.pixel_count(pixel_count), .frame_done(frame_done));

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk; // 8 ns period.
	end

	task automatic abort_run(input string why);
		$display("error: %s", why);
		$display("test failed");
		$finish;
	endtask

	//////////////////////////////////////////////////
	// data file into the three queues.
	//////////////////////////////////////////////////
	task automatic read_stimulus(output logic opened);
		int fd;
		int code;
		int a;
		int b;
		logic [sprite_pkg::cfg_data_w-1:0] d;
		logic [8*8-1:0] tag;
		logic [8*160-1:0] rest;
		fd = $fopen("verification/sprite_input.txt", "r");
		opened = (fd != 0);
		if (opened) begin
			while (!$feof(fd)) begin
				code = $fscanf(fd, " %s", tag);
				if (code == 1 && tag == "W") begin
					code = $fscanf(fd, " %d %h %h", a, b, d);
					wq_target.push_back(a);
					wq_addr.push_back(b[sprite_pkg::addr_w-1:0]);
					wq_data.push_back(d);
				end else if (code == 1 && tag == "X") begin
					code = $fscanf(fd, " %h %h", b, d);
					xq_addr.push_back(b[sprite_pkg::addr_w-1:0]);
					xq_data.push_back(d);
				end else if (code == 1 && tag == "E") begin
					code = $fscanf(fd, " %d %d %h", a, b, d);
					eq_x.push_back(a[sprite_pkg::x_w-1:0]);
					eq_y.push_back(b[sprite_pkg::y_w-1:0]);
					eq_c.push_back(d[sprite_pkg::color_w-1:0]);
				end else if (code == 1) begin
					code = $fgets(rest, fd); // rest of a comment line.
				end
			end
			$fclose(fd);
		end
	endtask

	task automatic host_write(input int target, input logic [sprite_pkg::addr_w-1:0] addr,
		input logic [sprite_pkg::cfg_data_w-1:0] data);
		@(negedge clk);
		cfg_strobe = 1'b1; // held for exactly one rising edge.
		cfg_target = sprite_pkg::cfg_target_e'(target);
		cfg_addr = addr;
		cfg_data = data;
		@(negedge clk);
		cfg_strobe = 1'b0;
	endtask

	initial begin
		cycle_count = 0;
		while (cycle_limit == 0 || cycle_count < cycle_limit) begin
			@(posedge clk);
			cycle_count++;
		end
		abort_run($sformatf("no complete frame within %0d cycles", cycle_limit));
	end

	initial begin
		int i;
		int fill;
		logic opened;
		seed = 5696;
		reset = 1'b0;
		video_enable = 1'b0;
		cfg_strobe = 1'b0;
		cfg_target = sprite_pkg::cfg_pixel_mem;
		cfg_addr = '0;
		cfg_data = '0;
		exp_strobe = 1'b0;
		exp_x = '0;
		exp_y = '0;
		exp_color = '0;
		cycle_limit = 0;
		read_stimulus(opened);
		if (!opened) begin
			abort_run("cannot open verification/sprite_input.txt");
		end else begin
			cycle_limit = 16 + 2 * (2 ** sprite_pkg::addr_w + wq_addr.size() + xq_addr.size()) +
				eq_x.size() + 2 * sprite_pkg::pixel_period * int'(sprite_pkg::h_total) *
				int'(sprite_pkg::v_total) + 10000; // setup, two frames and a margin.
			repeat (16) @(negedge clk);
			reset = 1'b1;
			for (i = 0; i < 2 ** sprite_pkg::addr_w; i++) begin
				fill = $random(seed);
				host_write(0, i[sprite_pkg::addr_w-1:0], fill[sprite_pkg::color_w-1:0]);
			end
			for (i = 0; i < wq_addr.size(); i++) host_write(wq_target[i], wq_addr[i], wq_data[i]);
			for (i = 0; i < eq_x.size(); i++) begin
				@(negedge clk);
				exp_strobe = 1'b1;
				exp_x = eq_x[i];
				exp_y = eq_y[i];
				exp_color = eq_c[i];
			end
			@(negedge clk);
			exp_strobe = 1'b0;
			video_enable = 1'b1; // the raster starts at the top left corner.
			for (i = 0; i < xq_addr.size(); i++) host_write(0, xq_addr[i], xq_data[i]);
			wait (frame_done === 1'b1);
			@(negedge clk);
			$display("pixels checked %0d, errors %0d", pixel_count, error_count);
			if (error_count == 0) begin
				$display("test passed");
			end else begin
				$display("test failed");
			end
			$finish;
		end
	end

endmodule

// File: verification/sprite_input.txt
# W target addr data is a host write before video starts, target 0 is pixel memory, 1 a slot.
# X addr data is a pixel memory write while video runs, E x y colour is expected in raster order.
W 0 3fff 5a
W 0 0100 11
W 0 0125 22
W 0 01aa 33
W 0 0222 44
W 0 02cc 55
W 0 0355 66
W 0 04ff 77
W 1 0 2320c8100
W 1 1 2360e8200
W 1 2 096320300
W 1 3 338740400
X 3fff a5
X 01aa ee
E 0 0 5a
E 639 0 5a
E 100 50 11
E 105 52 22
E 110 60 33
E 120 70 55
E 305 205 5a
E 320 240 5a
E 639 479 77
